// File: rtl/helix_map_pkg.sv
package helix_map_pkg;

  // Bus widths shared by every block on the link
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Region base addresses
  localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] REGS_BASE = 32'h2000_0000;

  // Register block layout
  localparam int unsigned REGS_WORDS = 4;
  localparam int unsigned REG_IDX_W  = $clog2(REGS_WORDS);
  localparam logic [ADDR_W-1:0] REGS_BYTES = ADDR_W'(4 * REGS_WORDS);

  // Word indices inside the register block
  localparam logic [REG_IDX_W-1:0] REG_BOOT0_IDX = 2'd0;
  localparam logic [REG_IDX_W-1:0] REG_BOOT1_IDX = 2'd1;
  localparam logic [REG_IDX_W-1:0] REG_ID_IDX    = 2'd2;
  // Index 3 reserved, reads as zero

  // Merge write data into an old word under byte enables
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] be
  );
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// File: rtl/helix_bus_pkg.sv
package helix_bus_pkg;

  // Response code returned with every ack
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  // Target exists but refused the access
  localparam resp_t RESP_SLVERR = 2'd2;
  // No target at this address
  localparam resp_t RESP_DECERR = 2'd3;

  // Requester ports on the link
  localparam int unsigned NUM_PORTS = 2;

  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

  // Core data path
  localparam port_idx_t PORT_CORE = 1'b0;
  // Host path from the APB side
  localparam port_idx_t PORT_HOST = 1'b1;

endpackage

// File: rtl/helix_port_ctrl.sv
`timescale 1ns/1ps

module helix_port_ctrl
  import helix_map_pkg::*;
  import helix_bus_pkg::*;
(
  input  logic              sysl_clk_i,
  input  logic              rst_n_i,
  // Requester side, four-phase req/ack
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] be_i,
  output logic              ack_o,
  output logic [DATA_W-1:0] rdata_o,
  output resp_t             resp_o,
  // Arbiter side
  input  logic              done_i,
  input  logic [DATA_W-1:0] done_rdata_i,
  input  resp_t             done_resp_i,
  output logic              pend_o,
  output logic              pend_we_o,
  output logic [ADDR_W-1:0] pend_addr_o,
  output logic [DATA_W-1:0] pend_wdata_o,
  output logic [STRB_W-1:0] pend_be_o
);

  // FSM encoding
  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_PEND     = 2'd1;
  // First ack cycle
  localparam logic [1:0] ST_ACKED    = 2'd2;
  // Requester still holding req after ack
  localparam logic [1:0] ST_WAIT_LOW = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:     if (req_i) state_d = ST_PEND;
      ST_PEND:     if (done_i) state_d = ST_ACKED;
      ST_ACKED:    state_d = req_i ? ST_WAIT_LOW : ST_IDLE;
      ST_WAIT_LOW: if (!req_i) state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge sysl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields latched on the rising req
  // Held stable while the arbiter works on them
  always_ff @(posedge sysl_clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      pend_we_o    <= we_i;
      pend_addr_o  <= addr_i;
      pend_wdata_o <= wdata_i;
      pend_be_o    <= be_i;
    end
  end

  // Response kept until the next transaction
  always_ff @(posedge sysl_clk_i) begin
    if (state_q == ST_PEND && done_i) begin
      rdata_o <= done_rdata_i;
      resp_o  <= done_resp_i;
    end
  end

  assign pend_o = (state_q == ST_PEND);

  // Ack high from the cycle after done until req seen low
  assign ack_o = (state_q == ST_ACKED) || (state_q == ST_WAIT_LOW);

endmodule

// File: rtl/helix_link_arbiter.sv
`timescale 1ns/1ps

module helix_link_arbiter
  import helix_map_pkg::*;
  import helix_bus_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic                             sysl_clk_i,
  input  logic                             rst_n_i,
  // Pending transactions, one per port
  input  logic [NUM_PORTS-1:0]             pend_i,
  input  logic [NUM_PORTS-1:0]             pend_we_i,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0] pend_addr_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] pend_wdata_i,
  input  logic [NUM_PORTS-1:0][STRB_W-1:0] pend_be_i,
  // Response back to the ports
  output logic [NUM_PORTS-1:0]             done_o,
  output logic [DATA_W-1:0]                done_rdata_o,
  output resp_t                            done_resp_o,
  // Scratch RAM
  output logic                             ram_en_o,
  output logic                             ram_we_o,
  output logic [$clog2(RAM_WORDS)-1:0]     ram_idx_o,
  output logic [DATA_W-1:0]                ram_wdata_o,
  output logic [STRB_W-1:0]                ram_be_o,
  input  logic [DATA_W-1:0]                ram_rdata_i,
  // Register block
  output logic                             reg_en_o,
  output logic                             reg_we_o,
  output logic [REG_IDX_W-1:0]             reg_idx_o,
  output logic [DATA_W-1:0]                reg_wdata_o,
  output logic [STRB_W-1:0]                reg_be_o,
  input  logic [DATA_W-1:0]                reg_rdata_i,
  input  logic                             reg_err_i
);

  localparam int unsigned       RAM_IDX_W = $clog2(RAM_WORDS);
  localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(4 * RAM_WORDS);

  port_idx_t            last_q;
  logic [NUM_PORTS-1:0] elig;
  logic                 gnt_vld;
  port_idx_t            gnt_port;

  // Response stage
  logic      rsp_vld_q;
  port_idx_t rsp_port_q;
  logic      rsp_ram_q;
  logic      rsp_dec_err_q;
  logic      rsp_we_q;

  ////////////////////
  // Grant

  // Port already in the response stage is not granted again
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      elig[p] = pend_i[p] && !(rsp_vld_q && rsp_port_q == port_idx_t'(p));
    end
  end

  // Round robin, last granted port loses a tie
  always_comb begin
    gnt_vld = |elig;
    if (elig[~last_q]) begin
      gnt_port = ~last_q;
    end else begin
      gnt_port = last_q;
    end
  end

  ////////////////////
  // Address decode

  logic [ADDR_W-1:0] g_addr;
  logic [ADDR_W-1:0] ram_off;
  logic [ADDR_W-1:0] reg_off;
  logic              hit_ram;
  logic              hit_reg;

  assign g_addr  = pend_addr_i[gnt_port];
  assign ram_off = g_addr - RAM_BASE;
  assign reg_off = g_addr - REGS_BASE;
  assign hit_ram = (g_addr >= RAM_BASE) && (ram_off < RAM_BYTES);
  assign hit_reg = (g_addr >= REGS_BASE) && (reg_off < REGS_BYTES);

  // Access issued in the grant cycle
  assign ram_en_o    = gnt_vld && hit_ram;
  assign ram_we_o    = pend_we_i[gnt_port];
  assign ram_idx_o   = ram_off[RAM_IDX_W+1:2];
  assign ram_wdata_o = pend_wdata_i[gnt_port];
  assign ram_be_o    = pend_be_i[gnt_port];

  assign reg_en_o    = gnt_vld && hit_reg;
  assign reg_we_o    = pend_we_i[gnt_port];
  assign reg_idx_o   = reg_off[REG_IDX_W+1:2];
  assign reg_wdata_o = pend_wdata_i[gnt_port];
  assign reg_be_o    = pend_be_i[gnt_port];

  ////////////////////
  // Response stage

  always_ff @(posedge sysl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Core port wins the first tie
      last_q        <= port_idx_t'(NUM_PORTS - 1);
      rsp_vld_q     <= 1'b0;
      rsp_port_q    <= '0;
      rsp_ram_q     <= 1'b0;
      rsp_dec_err_q <= 1'b0;
      rsp_we_q      <= 1'b0;
    end else begin
      rsp_vld_q <= gnt_vld;
      if (gnt_vld) begin
        last_q        <= gnt_port;
        rsp_port_q    <= gnt_port;
        rsp_ram_q     <= hit_ram;
        rsp_dec_err_q <= !hit_ram && !hit_reg;
        rsp_we_q      <= pend_we_i[gnt_port];
      end
    end
  end

  // One-cycle done pulse to the issuing port
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      done_o[p] = rsp_vld_q && (rsp_port_q == port_idx_t'(p));
    end
  end

  always_comb begin
    done_rdata_o = rsp_ram_q ? ram_rdata_i : reg_rdata_i;
    done_resp_o  = RESP_OKAY;
    if (rsp_dec_err_q) begin
      done_rdata_o = '0;
      done_resp_o  = RESP_DECERR;
    end else begin
      // Writes return zero read data
      if (rsp_we_q) done_rdata_o = '0;
      if (!rsp_ram_q && reg_err_i) done_resp_o = RESP_SLVERR;
    end
  end

endmodule

// File: rtl/helix_sram.sv
`timescale 1ns/1ps

module helix_sram
  import helix_map_pkg::*;
#(
  parameter int unsigned RAM_WORDS = 256
) (
  input  logic                         sysl_clk_i,
  input  logic                         en_i,
  input  logic                         we_i,
  input  logic [$clog2(RAM_WORDS)-1:0] idx_i,
  input  logic [DATA_W-1:0]            wdata_i,
  input  logic [STRB_W-1:0]            be_i,
  output logic [DATA_W-1:0]            rdata_o
);

  // Word array, contents unknown until written
  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [DATA_W-1:0] rdata_q;

  // Single port
  // Write under byte enables, read registered
  always_ff @(posedge sysl_clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[idx_i] <= be_merge(mem[idx_i], wdata_i, be_i);
      end else begin
        rdata_q <= mem[idx_i];
      end
    end
  end

  // Valid the cycle after the access
  assign rdata_o = rdata_q;

endmodule

// File: rtl/helix_ctrl_regs.sv
`timescale 1ns/1ps

module helix_ctrl_regs
  import helix_map_pkg::*;
#(
  parameter logic [DATA_W-1:0] CHIP_ID = 32'h484C_5801
) (
  input  logic                 sysl_clk_i,
  input  logic                 rst_n_i,
  input  logic                 en_i,
  input  logic                 we_i,
  input  logic [REG_IDX_W-1:0] idx_i,
  input  logic [DATA_W-1:0]    wdata_i,
  input  logic [STRB_W-1:0]    be_i,
  output logic [DATA_W-1:0]    rdata_o,
  output logic                 err_o
);

  // Boot addresses for the two cores
  logic [DATA_W-1:0] boot0_q;
  logic [DATA_W-1:0] boot1_q;
  logic [DATA_W-1:0] rd_word;
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;
  logic              wr_ro;

  // Read mux
  always_comb begin
    case (idx_i)
      REG_BOOT0_IDX: rd_word = boot0_q;
      REG_BOOT1_IDX: rd_word = boot1_q;
      REG_ID_IDX:    rd_word = CHIP_ID;
      default:       rd_word = '0;
    endcase
  end

  // ID and reserved word are read only
  assign wr_ro = we_i && (idx_i != REG_BOOT0_IDX) && (idx_i != REG_BOOT1_IDX);

  always_ff @(posedge sysl_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot0_q <= '0;
      boot1_q <= '0;
      err_q   <= 1'b0;
    end else begin
      // Error flag lines up with the read data
      err_q <= en_i && wr_ro;
      if (en_i && we_i && idx_i == REG_BOOT0_IDX) begin
        boot0_q <= be_merge(boot0_q, wdata_i, be_i);
      end
      if (en_i && we_i && idx_i == REG_BOOT1_IDX) begin
        boot1_q <= be_merge(boot1_q, wdata_i, be_i);
      end
    end
  end

  // Registered read, same latency as the RAM
  always_ff @(posedge sysl_clk_i) begin
    if (en_i) rdata_q <= rd_word;
  end

  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

// File: rtl/helix_link_top.sv
`timescale 1ns/1ps

module helix_link_top
  import helix_map_pkg::*;
  import helix_bus_pkg::*;
#(
  parameter int unsigned       RAM_WORDS = 256,
  parameter logic [DATA_W-1:0] CHIP_ID   = 32'h484C_5801
) (
  input  logic              sysl_clk_i,
  input  logic              rst_n_i,
  // Core data port
  input  logic              core_req_i,
  input  logic              core_we_i,
  input  logic [ADDR_W-1:0] core_addr_i,
  input  logic [DATA_W-1:0] core_wdata_i,
  input  logic [STRB_W-1:0] core_be_i,
  output logic              core_ack_o,
  output logic [DATA_W-1:0] core_rdata_o,
  output resp_t             core_resp_o,
  // Host port
  input  logic              host_req_i,
  input  logic              host_we_i,
  input  logic [ADDR_W-1:0] host_addr_i,
  input  logic [DATA_W-1:0] host_wdata_i,
  input  logic [STRB_W-1:0] host_be_i,
  output logic              host_ack_o,
  output logic [DATA_W-1:0] host_rdata_o,
  output resp_t             host_resp_o
);

  ////////////////////
  // Internal signals

  logic [NUM_PORTS-1:0]             pend;
  logic [NUM_PORTS-1:0]             pend_we;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] pend_addr;
  logic [NUM_PORTS-1:0][DATA_W-1:0] pend_wdata;
  logic [NUM_PORTS-1:0][STRB_W-1:0] pend_be;
  logic [NUM_PORTS-1:0]             done;
  logic [DATA_W-1:0]                done_rdata;
  resp_t                            done_resp;

  logic                             ram_en;
  logic                             ram_we;
  logic [$clog2(RAM_WORDS)-1:0]     ram_idx;
  logic [DATA_W-1:0]                ram_wdata;
  logic [STRB_W-1:0]                ram_be;
  logic [DATA_W-1:0]                ram_rdata;

  logic                             reg_en;
  logic                             reg_we;
  logic [REG_IDX_W-1:0]             reg_idx;
  logic [DATA_W-1:0]                reg_wdata;
  logic [STRB_W-1:0]                reg_be;
  logic [DATA_W-1:0]                reg_rdata;
  logic                             reg_err;

  ////////////////////
  // Port controllers

  helix_port_ctrl u_core_port (
    .sysl_clk_i  (sysl_clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (core_req_i),
    .we_i        (core_we_i),
    .addr_i      (core_addr_i),
    .wdata_i     (core_wdata_i),
    .be_i        (core_be_i),
    .ack_o       (core_ack_o),
    .rdata_o     (core_rdata_o),
    .resp_o      (core_resp_o),
    .done_i      (done[PORT_CORE]),
    .done_rdata_i(done_rdata),
    .done_resp_i (done_resp),
    .pend_o      (pend[PORT_CORE]),
    .pend_we_o   (pend_we[PORT_CORE]),
    .pend_addr_o (pend_addr[PORT_CORE]),
    .pend_wdata_o(pend_wdata[PORT_CORE]),
    .pend_be_o   (pend_be[PORT_CORE])
  );

  helix_port_ctrl u_host_port (
    .sysl_clk_i  (sysl_clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (host_req_i),
    .we_i        (host_we_i),
    .addr_i      (host_addr_i),
    .wdata_i     (host_wdata_i),
    .be_i        (host_be_i),
    .ack_o       (host_ack_o),
    .rdata_o     (host_rdata_o),
    .resp_o      (host_resp_o),
    .done_i      (done[PORT_HOST]),
    .done_rdata_i(done_rdata),
    .done_resp_i (done_resp),
    .pend_o      (pend[PORT_HOST]),
    .pend_we_o   (pend_we[PORT_HOST]),
    .pend_addr_o (pend_addr[PORT_HOST]),
    .pend_wdata_o(pend_wdata[PORT_HOST]),
    .pend_be_o   (pend_be[PORT_HOST])
  );

  ////////////////////
  // System link

  helix_link_arbiter #(
    .RAM_WORDS(RAM_WORDS)
  ) u_arbiter (
    .sysl_clk_i  (sysl_clk_i),
    .rst_n_i     (rst_n_i),
    .pend_i      (pend),
    .pend_we_i   (pend_we),
    .pend_addr_i (pend_addr),
    .pend_wdata_i(pend_wdata),
    .pend_be_i   (pend_be),
    .done_o      (done),
    .done_rdata_o(done_rdata),
    .done_resp_o (done_resp),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_idx_o   (ram_idx),
    .ram_wdata_o (ram_wdata),
    .ram_be_o    (ram_be),
    .ram_rdata_i (ram_rdata),
    .reg_en_o    (reg_en),
    .reg_we_o    (reg_we),
    .reg_idx_o   (reg_idx),
    .reg_wdata_o (reg_wdata),
    .reg_be_o    (reg_be),
    .reg_rdata_i (reg_rdata),
    .reg_err_i   (reg_err)
  );

  ////////////////////
  // Targets

  helix_sram #(
    .RAM_WORDS(RAM_WORDS)
  ) u_sram (
    .sysl_clk_i(sysl_clk_i),
    .en_i      (ram_en),
    .we_i      (ram_we),
    .idx_i     (ram_idx),
    .wdata_i   (ram_wdata),
    .be_i      (ram_be),
    .rdata_o   (ram_rdata)
  );

  helix_ctrl_regs #(
    .CHIP_ID(CHIP_ID)
  ) u_ctrl_regs (
    .sysl_clk_i(sysl_clk_i),
    .rst_n_i   (rst_n_i),
    .en_i      (reg_en),
    .we_i      (reg_we),
    .idx_i     (reg_idx),
    .wdata_i   (reg_wdata),
    .be_i      (reg_be),
    .rdata_o   (reg_rdata),
    .err_o     (reg_err)
  );

endmodule

// File: testbench/helix_clk_gen.sv
`timescale 1ns/1ps

module helix_clk_gen #(
  parameter int unsigned HALF_NS    = 10,
  parameter int unsigned RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  // Reset low for 8 rising edges, released just after the last one
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: testbench/helix_link_props.sv
`timescale 1ns/1ps

module helix_link_props
  import helix_bus_pkg::*;
(
  input logic  sysl_clk_i,
  input logic  rst_n_i,
  input logic  req_i,
  input logic  ack_i,
  input resp_t resp_i
);

  ////////////////////
  // Four-phase order

  // Ack only rises into a live request
  ack_rise_needs_req: assert property (
    @(posedge sysl_clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i)
  ) else $error("ack rose while req was low");

  // Ack held for as long as the requester keeps req high
  ack_held_with_req: assert property (
    @(posedge sysl_clk_i) disable iff (!rst_n_i)
    ack_i && req_i |=> ack_i
  ) else $error("ack fell before req was released");

  // Response code valid whenever it is presented
  resp_known_with_ack: assert property (
    @(posedge sysl_clk_i) disable iff (!rst_n_i)
    ack_i |-> !$isunknown(resp_i)
  ) else $error("resp has unknown bits while ack is high");

endmodule

// One checker per port controller
bind helix_port_ctrl helix_link_props u_props (
  .sysl_clk_i(sysl_clk_i),
  .rst_n_i   (rst_n_i),
  .req_i     (req_i),
  .ack_i     (ack_o),
  .resp_i    (resp_o)
);

// File: testbench/helix_link_tb.sv
`timescale 1ns/1ps

module helix_link_tb
  import helix_map_pkg::*;
  import helix_bus_pkg::*;
();

  localparam string DATA_FILE = "testbench/helix_link_testdata.txt";
  localparam int    DRIVE_DLY = 1;

  logic              sysl_clk;
  logic              rst_n;
  logic              core_req;
  logic              core_we;
  logic [ADDR_W-1:0] core_addr;
  logic [DATA_W-1:0] core_wdata;
  logic [STRB_W-1:0] core_be;
  logic              core_ack;
  logic [DATA_W-1:0] core_rdata;
  resp_t             core_resp;
  logic              host_req;
  logic              host_we;
  logic [ADDR_W-1:0] host_addr;
  logic [DATA_W-1:0] host_wdata;
  logic [STRB_W-1:0] host_be;
  logic              host_ack;
  logic [DATA_W-1:0] host_rdata;
  resp_t             host_resp;

  // Transactions from the data file
  string             t_name[$];
  int                t_grp[$];
  int                t_port[$];
  logic              t_hold[$];
  logic              t_we[$];
  logic [ADDR_W-1:0] t_addr[$];
  logic [DATA_W-1:0] t_wdata[$];
  logic [STRB_W-1:0] t_be[$];
  logic [DATA_W-1:0] t_rdata[$];
  resp_t             t_resp[$];

  // Port still holding req after its ack
  logic held [NUM_PORTS];
  int   n_checks = 0;
  int   data_errs = 0;
  int   resp_errs = 0;
  int   lat_errs = 0;
  int   proto_errs = 0;
  int   file_errs = 0;
  int   cycles = 0;
  int   limit_cycles = 0;

  helix_clk_gen u_clk_gen (
    .clk_o  (sysl_clk),
    .rst_n_o(rst_n)
  );

  helix_link_top #(
    .RAM_WORDS(256),
    .CHIP_ID  (32'h484C_5801)
  ) dut_i (
    .sysl_clk_i  (sysl_clk),
    .rst_n_i     (rst_n),
    .core_req_i  (core_req),
    .core_we_i   (core_we),
    .core_addr_i (core_addr),
    .core_wdata_i(core_wdata),
    .core_be_i   (core_be),
    .core_ack_o  (core_ack),
    .core_rdata_o(core_rdata),
    .core_resp_o (core_resp),
    .host_req_i  (host_req),
    .host_we_i   (host_we),
    .host_addr_i (host_addr),
    .host_wdata_i(host_wdata),
    .host_be_i   (host_be),
    .host_ack_o  (host_ack),
    .host_rdata_o(host_rdata),
    .host_resp_o (host_resp)
  );

  ////////////////////
  // Data file

  task automatic load_testdata();
    int                fd;
    int                cnt;
    string             line;
    logic [7:0]        c0;
    string             name_v;
    int                grp_v, port_v, we_v, resp_v;
    logic [ADDR_W-1:0] addr_v;
    logic [DATA_W-1:0] wdata_v, rdata_v;
    logic [STRB_W-1:0] be_v;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      file_errs++;
      $display("Cannot open %s", DATA_FILE);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      c0 = line.getc(0);
      // Skip comments and blank lines
      if (line.len() == 0 || c0 == "#" || c0 == "\n" || c0 == "\r") continue;
      cnt = $sscanf(line, "%s %d %d %d %h %h %h %h %d", name_v, grp_v, port_v, we_v,
                    addr_v, wdata_v, be_v, rdata_v, resp_v);
      if (cnt != 9) begin
        file_errs++;
        $display("Malformed testdata line: %s", line);
      end else begin
        t_name.push_back(name_v);
        t_grp.push_back(grp_v);
        // Port code 2 is the host port with req held after ack
        t_port.push_back((port_v == 0) ? 0 : 1);
        t_hold.push_back(port_v == 2);
        t_we.push_back(we_v != 0);
        t_addr.push_back(addr_v);
        t_wdata.push_back(wdata_v);
        t_be.push_back(be_v);
        t_rdata.push_back(rdata_v);
        t_resp.push_back(resp_t'(resp_v));
      end
    end
    $fclose(fd);
  endtask

  ////////////////////
  // Port access

  task automatic next_cycle();
    @(posedge sysl_clk);
    #DRIVE_DLY;
  endtask

  task automatic drive_req(input int port, input int idx);
    if (port == 0) begin
      core_we    = t_we[idx];
      core_addr  = t_addr[idx];
      core_wdata = t_wdata[idx];
      core_be    = t_be[idx];
      core_req   = 1'b1;
    end else begin
      host_we    = t_we[idx];
      host_addr  = t_addr[idx];
      host_wdata = t_wdata[idx];
      host_be    = t_be[idx];
      host_req   = 1'b1;
    end
  endtask

  task automatic drop_req(input int port);
    if (port == 0) core_req = 1'b0;
    else host_req = 1'b0;
  endtask

  function automatic logic ack_of(input int port);
    return (port == 0) ? core_ack : host_ack;
  endfunction

  function automatic logic [DATA_W-1:0] rdata_of(input int port);
    return (port == 0) ? core_rdata : host_rdata;
  endfunction

  function automatic resp_t resp_of(input int port);
    return (port == 0) ? core_resp : host_resp;
  endfunction

  task automatic wait_ack_low(input int port);
    while (ack_of(port)) next_cycle();
  endtask

  // One full handshake, checked when ack shows up
  task automatic run_txn(input int port, input int idx);
    int                lat;
    logic [DATA_W-1:0] got_rdata;
    resp_t             got_resp;
    lat = 0;
    drive_req(port, idx);
    do begin
      next_cycle();
      lat++;
    end while (!ack_of(port));
    got_rdata = rdata_of(port);
    got_resp  = resp_of(port);
    n_checks++;
    if (got_rdata !== t_rdata[idx]) begin
      data_errs++;
      $display("** Error %s: rdata expected %h, actual %h", t_name[idx], t_rdata[idx],
               got_rdata);
    end
    if (got_resp !== t_resp[idx]) begin
      resp_errs++;
      $display("** Error %s: resp expected %0d, actual %0d", t_name[idx], t_resp[idx],
               got_resp);
    end
    // 3 cycles alone, 1 more when the other port wins the grant
    if (lat < 3 || lat > 4) begin
      lat_errs++;
      $display("** Error %s: ack latency expected 3 to 4 cycles, actual %0d", t_name[idx],
               lat);
    end
    if (t_hold[idx]) begin
      held[port] = 1'b1;
    end else begin
      drop_req(port);
      wait_ack_low(port);
    end
  endtask

  // End of back-pressure, ack must have stayed up all along
  task automatic release_port(input int port);
    if (!ack_of(port)) begin
      proto_errs++;
      $display("Port %0d let ack fall while its req was still held high", port);
    end
    drop_req(port);
    wait_ack_low(port);
    held[port] = 1'b0;
  endtask

  ////////////////////
  // Main sequence

  initial begin
    int unsigned seed;
    int          i, j, idle, slot_core, slot_host, total;
    core_req   = 1'b0;
    core_we    = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_be    = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    held[0]    = 1'b0;
    held[1]    = 1'b0;
    seed = $urandom(8);
    load_testdata();
    if (t_name.size() == 0) begin
      file_errs++;
      $display("No transactions found in %s", DATA_FILE);
    end
    limit_cycles = t_name.size() * 40 + 100;
    @(posedge rst_n);
    next_cycle();
    i = 0;
    while (i < t_name.size()) begin
      slot_core = -1;
      slot_host = -1;
      j = i;
      // Lines of one group start together, one per port
      while (j < t_name.size() && t_grp[j] == t_grp[i]) begin
        if ((t_port[j] == 0 && slot_core >= 0) || (t_port[j] == 1 && slot_host >= 0)) begin
          file_errs++;
          $display("Group %0d uses port %0d twice", t_grp[j], t_port[j]);
        end else if (t_port[j] == 0) begin
          slot_core = j;
        end else begin
          slot_host = j;
        end
        j++;
      end
      if (slot_core >= 0 && held[0]) release_port(0);
      if (slot_host >= 0 && held[1]) release_port(1);
      idle = $urandom_range(3, 0);
      repeat (idle) next_cycle();
      fork
        begin
          if (slot_core >= 0) run_txn(0, slot_core);
        end
        begin
          if (slot_host >= 0) run_txn(1, slot_host);
        end
      join
      i = j;
    end
    if (held[0]) release_port(0);
    if (held[1]) release_port(1);
    total = data_errs + resp_errs + lat_errs + proto_errs + file_errs;
    $display("Checks %0d, errors: data %0d, resp %0d, latency %0d, protocol %0d, file %0d",
             n_checks, data_errs, resp_errs, lat_errs, proto_errs, file_errs);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, limit scales with the number of transactions
  initial begin
    wait (limit_cycles > 0);
    while (cycles < limit_cycles) begin
      @(posedge sysl_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, transactions did not finish", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: testbench/helix_link_testdata.txt
# name grp port we addr wdata be exp_rdata exp_resp
# port 0 core, 1 host, 2 host holding req after ack; addr, data and be in hex
ram_wr_full       1 0 1 10000000 deadbeef f 00000000 0
ram_rd_full       2 0 0 10000000 00000000 0 deadbeef 0
ram_wr_low_half   3 0 1 10000000 11223344 3 00000000 0
ram_rd_low_half   4 0 0 10000000 00000000 0 dead3344 0
ram_wr_byte2      5 0 1 10000000 00990000 4 00000000 0
ram_rd_byte2      6 0 0 10000000 00000000 0 de993344 0
ram_wr_last       7 0 1 100003fc 0badf00d f 00000000 0
ram_rd_last       8 0 0 100003fc 00000000 0 0badf00d 0
boot0_rst         9 1 0 20000000 00000000 0 00000000 0
boot1_rst        10 1 0 20000004 00000000 0 00000000 0
boot0_wr         11 1 1 20000000 80001000 f 00000000 0
boot0_rd         12 1 0 20000000 00000000 0 80001000 0
boot1_wr_hi      13 1 1 20000004 abcd1234 c 00000000 0
boot1_rd_hi      14 1 0 20000004 00000000 0 abcd0000 0
chip_id_rd       15 1 0 20000008 00000000 0 484c5801 0
chip_id_wr       16 1 1 20000008 ffffffff f 00000000 2
chip_id_rd_again 17 1 0 20000008 00000000 0 484c5801 0
rsvd_wr          18 1 1 2000000c 12345678 f 00000000 2
rsvd_rd          19 1 0 2000000c 00000000 0 00000000 0
unmap_rd         20 0 0 30000000 00000000 0 00000000 3
unmap_wr         21 1 1 00000000 cafef00d f 00000000 3
ram_end_rd       22 0 0 10000400 00000000 0 00000000 3
regs_end_wr      23 1 1 20000010 00000001 f 00000000 3
dual_wr_core     24 0 1 10000010 a5a50001 f 00000000 0
dual_wr_host     24 1 1 10000014 5a5a0002 f 00000000 0
dual_rd_core     25 0 0 10000014 00000000 0 5a5a0002 0
dual_rd_host     25 1 0 10000010 00000000 0 a5a50001 0
hold_host_rd     26 2 0 20000000 00000000 0 80001000 0
hold_core_wr     27 0 1 10000020 00c0ffee f 00000000 0
hold_core_rd     28 0 0 10000020 00000000 0 00c0ffee 0
after_hold_rd    29 1 0 20000004 00000000 0 abcd0000 0

// File: helix_link.f
rtl/helix_map_pkg.sv
rtl/helix_bus_pkg.sv
rtl/helix_port_ctrl.sv
rtl/helix_link_arbiter.sv
rtl/helix_sram.sv
rtl/helix_ctrl_regs.sv
rtl/helix_link_top.sv
testbench/helix_clk_gen.sv
testbench/helix_link_props.sv
testbench/helix_link_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := helix_link_tb
FILELIST := helix_link.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
